// ==== hw/bpu_cfg_pkg.sv ====
//----------------------------------------------------------
// BPU configuration
// Address width, table sizes and the field widths derived
// from them for the two-wide gshare predictor
//----------------------------------------------------------
package bpu_cfg_pkg;

   // Byte address, fetch works on word PCs
   localparam int ncpu_aw = 32;
   localparam int pc_w = ncpu_aw - 2;

   // PHT index width, also the global history length
   localparam int pht_num_log2 = 8;
   localparam int btb_num_log2 = 6;

   localparam int btb_tag_w = pc_w - btb_num_log2;
   localparam int cnt_w = 2;

   // Two counter values plus both table indices
   localparam int upd_w = pht_num_log2 + btb_num_log2 + 2 * cnt_w;

   // Valid, is_bcc, tag and target
   localparam int btb_dw = 1 + 1 + btb_tag_w + pc_w;

   // Counter state after reset
   localparam logic [cnt_w-1:0] cnt_weak_nt = 2'b01;

endpackage

// ==== hw/bpu_types_pkg.sv ====
//----------------------------------------------------------
// BPU types
// Vector types for PCs, table indices, counters, tags and
// the update word that travels with each instruction
//----------------------------------------------------------
package bpu_types_pkg;

   import bpu_cfg_pkg::*;

   // Word address
   typedef logic [pc_w-1:0] pc_t;

   typedef logic [pht_num_log2-1:0] pht_idx_t;
   typedef logic [btb_num_log2-1:0] btb_idx_t;
   typedef logic [btb_tag_w-1:0] btb_tag_t;

   // 2-bit saturating counter, upper bit is the taken prediction
   typedef logic [cnt_w-1:0] cnt_t;

   // From MSB: counter if taken, counter if not taken,
   // PHT index, BTB index
   typedef logic [upd_w-1:0] bpu_upd_t;

endpackage

// ==== hw/bpu_wb_if.sv ====
//----------------------------------------------------------
// BPU writeback bus
// Resolved branch outcome and its update word, sent back
// from writeback to train the BTB and the PHT
//----------------------------------------------------------
`timescale 1ns/1ps

interface bpu_wb_if
   import bpu_types_pkg::*;
();

   // One-cycle strobe, the fields below are valid while high
   logic wb;
   logic is_bcc;
   logic is_breg;
   logic taken;
   pc_t pc;
   // Next PC as actually resolved
   pc_t pc_nxt_act;
   bpu_upd_t upd;

   modport src (output wb, is_bcc, is_breg, taken, pc, pc_nxt_act, upd);

   // BTB installs targets, it has no use for the outcome bit
   modport btb_sink (input wb, is_bcc, is_breg, pc, pc_nxt_act, upd);

   // PHT trains counters and history on conditional branches only
   modport pht_sink (input wb, is_bcc, taken, upd);

endinterface

// ==== hw/mpram_1w2r.sv ====
//----------------------------------------------------------
// Register-array memory, one write and two read ports
// Reads are registered on re, writes land at the edge,
// all entries reset asynchronously to reset_val
//----------------------------------------------------------
`timescale 1ns/1ps

module mpram_1w2r
#(
   parameter int aw = 6,
   parameter int dw = 8,
   parameter logic [dw-1:0] reset_val = '0
)
(
   input  logic          clk,
   input  logic          arst_n,
   input  logic          re,
   input  logic [aw-1:0] raddr_1,
   input  logic [aw-1:0] raddr_2,
   input  logic [aw-1:0] waddr,
   input  logic          we,
   input  logic [dw-1:0] din,
   output logic [dw-1:0] dout_1,
   output logic [dw-1:0] dout_2
);

   logic [dw-1:0] mem [0:(1<<aw)-1];

   // Write port
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         for (int i = 0; i < (1 << aw); i++)
            mem[i] <= reset_val;
      end
      else if (we)
      begin
         mem[waddr] <= din;
      end
   end

   // Read registers, hold while re is low
   // No bypass, a same-edge write is seen one lookup later
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         dout_1 <= reset_val;
         dout_2 <= reset_val;
      end
      else if (re)
      begin
         dout_1 <= mem[raddr_1];
         dout_2 <= mem[raddr_2];
      end
   end

endmodule

// ==== hw/bpu_btb.sv ====
//----------------------------------------------------------
// Branch target buffer
// Direct mapped, two lookups per cycle with tag compare,
// entries installed from resolved branches at writeback
//----------------------------------------------------------
`timescale 1ns/1ps

module bpu_btb
   import bpu_cfg_pkg::*;
   import bpu_types_pkg::*;
(
   input  logic       clk,
   input  logic       arst_n,
   input  logic       re,
   input  btb_idx_t   btb_idx_1,
   input  btb_idx_t   btb_idx_2,
   // Fetch PCs registered alongside the read
   input  pc_t        pc_r_1,
   input  pc_t        pc_r_2,
   output logic       hit_1,
   output logic       hit_2,
   output logic       is_bcc_1,
   output logic       is_bcc_2,
   output pc_t        target_1,
   output pc_t        target_2,
   bpu_wb_if.btb_sink btb_sink
);

   logic [btb_dw-1:0] entry_1;
   logic [btb_dw-1:0] entry_2;
   logic [btb_dw-1:0] wr_entry;
   logic              v_1;
   logic              v_2;
   btb_tag_t          tag_1;
   btb_tag_t          tag_2;
   btb_idx_t          wr_idx;
   logic              we;

   // Conditional and register branches both get an entry
   assign we = btb_sink.wb & (btb_sink.is_bcc | btb_sink.is_breg);

   // BTB index sits in the low bits of the update word
   assign wr_idx = btb_sink.upd[btb_num_log2-1:0];

   assign wr_entry = {1'b1,
                      btb_sink.is_bcc,
                      btb_sink.pc[pc_w-1:btb_num_log2],
                      btb_sink.pc_nxt_act};

   mpram_1w2r
   #(
      .aw        (btb_num_log2),
      .dw        (btb_dw),
      .reset_val ({btb_dw{1'b0}})
   )
   u_btb_mem
   (
      .clk     (clk),
      .arst_n  (arst_n),
      .re      (re),
      .raddr_1 (btb_idx_1),
      .raddr_2 (btb_idx_2),
      .waddr   (wr_idx),
      .we      (we),
      .din     (wr_entry),
      .dout_1  (entry_1),
      .dout_2  (entry_2)
   );

   assign {v_1, is_bcc_1, tag_1, target_1} = entry_1;
   assign {v_2, is_bcc_2, tag_2, target_2} = entry_2;

   // Tag is the PC above the index bits
   assign hit_1 = v_1 & (tag_1 == pc_r_1[pc_w-1:btb_num_log2]);
   assign hit_2 = v_2 & (tag_2 == pc_r_2[pc_w-1:btb_num_log2]);

endmodule

// ==== hw/bpu_pht.sv ====
//----------------------------------------------------------
// Gshare pattern history table
// 2-bit counters indexed by PC XOR global history, trained
// and shifted on conditional-branch writebacks
//----------------------------------------------------------
`timescale 1ns/1ps

module bpu_pht
   import bpu_cfg_pkg::*;
   import bpu_types_pkg::*;
(
   input  logic       clk,
   input  logic       arst_n,
   input  logic       re,
   input  pc_t        pc_1,
   input  pc_t        pc_2,
   output logic       taken_1,
   output logic       taken_2,
   output cnt_t       cnt_inc_1,
   output cnt_t       cnt_inc_2,
   output cnt_t       cnt_dec_1,
   output cnt_t       cnt_dec_2,
   output pht_idx_t   pht_idx_r_1,
   output pht_idx_t   pht_idx_r_2,
   bpu_wb_if.pht_sink pht_sink
);

   pht_idx_t ghr;
   pht_idx_t idx_1;
   pht_idx_t idx_2;
   cnt_t     cnt_1;
   cnt_t     cnt_2;
   logic     we;
   pht_idx_t wr_idx;
   cnt_t     wr_cnt;

   function automatic pht_idx_t hash (input pc_t pc, input pht_idx_t hist);
      return pc[pht_num_log2-1:0] ^ hist;
   endfunction

   function automatic cnt_t sat_inc (input cnt_t cnt);
      return (cnt == '1) ? cnt : cnt + cnt_t'(1);
   endfunction

   function automatic cnt_t sat_dec (input cnt_t cnt);
      return (cnt == '0) ? cnt : cnt - cnt_t'(1);
   endfunction

   assign idx_1 = hash(pc_1, ghr);
   assign idx_2 = hash(pc_2, ghr);

   // Index goes out with the counter so writeback hits the same entry
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         pht_idx_r_1 <= '0;
         pht_idx_r_2 <= '0;
      end
      else if (re)
      begin
         pht_idx_r_1 <= idx_1;
         pht_idx_r_2 <= idx_2;
      end
   end

   mpram_1w2r
   #(
      .aw        (pht_num_log2),
      .dw        (cnt_w),
      .reset_val (cnt_weak_nt)
   )
   u_pht_mem
   (
      .clk     (clk),
      .arst_n  (arst_n),
      .re      (re),
      .raddr_1 (idx_1),
      .raddr_2 (idx_2),
      .waddr   (wr_idx),
      .we      (we),
      .din     (wr_cnt),
      .dout_1  (cnt_1),
      .dout_2  (cnt_2)
   );

   assign taken_1 = cnt_1[cnt_w-1];
   assign taken_2 = cnt_2[cnt_w-1];
   assign cnt_inc_1 = sat_inc(cnt_1);
   assign cnt_inc_2 = sat_inc(cnt_2);
   assign cnt_dec_1 = sat_dec(cnt_1);
   assign cnt_dec_2 = sat_dec(cnt_2);

   assign we = pht_sink.wb & pht_sink.is_bcc;
   assign wr_idx = pht_sink.upd[btb_num_log2 +: pht_num_log2];

   // Pick the precomputed next counter by the resolved outcome
   assign wr_cnt = pht_sink.taken ? pht_sink.upd[upd_w-1 -: cnt_w]
                                  : pht_sink.upd[upd_w-cnt_w-1 -: cnt_w];

   // Newest outcome enters at the LSB
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         ghr <= '0;
      else if (we)
         ghr <= {ghr[pht_num_log2-2:0], pht_sink.taken};
   end

endmodule

// ==== hw/bpu_gshare.sv ====
//----------------------------------------------------------
// Two-channel gshare predictor
// Looks up BTB and PHT per fetch channel, picks the next
// PC and packs the update word for writeback
//----------------------------------------------------------
`timescale 1ns/1ps

module bpu_gshare
   import bpu_cfg_pkg::*;
   import bpu_types_pkg::*;
(
   input  logic     clk,
   input  logic     arst_n,
   input  logic     re,
   input  pc_t      insn_pc_1,
   input  pc_t      insn_pc_2,
   output pc_t      pred_pc_nxt_1,
   output pc_t      pred_pc_nxt_2,
   output bpu_upd_t pred_upd_1,
   output bpu_upd_t pred_upd_2,
   bpu_wb_if        wb_sink
);

   pc_t      pc_r_1;
   pc_t      pc_r_2;
   btb_idx_t btb_idx_1;
   btb_idx_t btb_idx_2;
   btb_idx_t btb_idx_r_1;
   btb_idx_t btb_idx_r_2;
   logic     hit_1;
   logic     hit_2;
   logic     is_bcc_1;
   logic     is_bcc_2;
   pc_t      target_1;
   pc_t      target_2;
   logic     taken_1;
   logic     taken_2;
   cnt_t     cnt_inc_1;
   cnt_t     cnt_inc_2;
   cnt_t     cnt_dec_1;
   cnt_t     cnt_dec_2;
   pht_idx_t pht_idx_r_1;
   pht_idx_t pht_idx_r_2;

   assign btb_idx_1 = insn_pc_1[btb_num_log2-1:0];
   assign btb_idx_2 = insn_pc_2[btb_num_log2-1:0];

   // Line up with the registered table reads
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         pc_r_1 <= '0;
         pc_r_2 <= '0;
         btb_idx_r_1 <= '0;
         btb_idx_r_2 <= '0;
      end
      else if (re)
      begin
         pc_r_1 <= insn_pc_1;
         pc_r_2 <= insn_pc_2;
         btb_idx_r_1 <= btb_idx_1;
         btb_idx_r_2 <= btb_idx_2;
      end
   end

   bpu_btb u_btb
   (
      .clk       (clk),
      .arst_n    (arst_n),
      .re        (re),
      .btb_idx_1 (btb_idx_1),
      .btb_idx_2 (btb_idx_2),
      .pc_r_1    (pc_r_1),
      .pc_r_2    (pc_r_2),
      .hit_1     (hit_1),
      .hit_2     (hit_2),
      .is_bcc_1  (is_bcc_1),
      .is_bcc_2  (is_bcc_2),
      .target_1  (target_1),
      .target_2  (target_2),
      .btb_sink  (wb_sink)
   );

   bpu_pht u_pht
   (
      .clk         (clk),
      .arst_n      (arst_n),
      .re          (re),
      .pc_1        (insn_pc_1),
      .pc_2        (insn_pc_2),
      .taken_1     (taken_1),
      .taken_2     (taken_2),
      .cnt_inc_1   (cnt_inc_1),
      .cnt_inc_2   (cnt_inc_2),
      .cnt_dec_1   (cnt_dec_1),
      .cnt_dec_2   (cnt_dec_2),
      .pht_idx_r_1 (pht_idx_r_1),
      .pht_idx_r_2 (pht_idx_r_2),
      .pht_sink    (wb_sink)
   );

   // Register branches always redirect, conditional ones only if taken
   assign pred_pc_nxt_1 = (hit_1 & (~is_bcc_1 | taken_1)) ? target_1 : pc_r_1 + pc_t'(1);
   assign pred_pc_nxt_2 = (hit_2 & (~is_bcc_2 | taken_2)) ? target_2 : pc_r_2 + pc_t'(1);

   assign pred_upd_1 = {cnt_inc_1, cnt_dec_1, pht_idx_r_1, btb_idx_r_1};
   assign pred_upd_2 = {cnt_inc_2, cnt_dec_2, pht_idx_r_2, btb_idx_r_2};

endmodule

// ==== hw/bpu_top.sv ====
//----------------------------------------------------------
// BPU top level
// Plain fetch and writeback ports, writeback fields are
// gathered onto one bus for the predictor
//----------------------------------------------------------
`timescale 1ns/1ps

module bpu_top
   import bpu_types_pkg::*;
(
   input  logic     clk,
   input  logic     arst_n,
   // Fetch side
   input  logic     re,
   input  pc_t      insn_pc_1,
   input  pc_t      insn_pc_2,
   output pc_t      pred_pc_nxt_1,
   output pc_t      pred_pc_nxt_2,
   output bpu_upd_t pred_upd_1,
   output bpu_upd_t pred_upd_2,
   // Writeback side
   input  logic     wb,
   input  logic     wb_is_bcc,
   input  logic     wb_is_breg,
   input  logic     wb_taken,
   input  pc_t      wb_pc,
   input  pc_t      wb_pc_nxt_act,
   input  bpu_upd_t wb_upd
);

   bpu_wb_if wb_bus ();

   assign wb_bus.wb = wb;
   assign wb_bus.is_bcc = wb_is_bcc;
   assign wb_bus.is_breg = wb_is_breg;
   assign wb_bus.taken = wb_taken;
   assign wb_bus.pc = wb_pc;
   assign wb_bus.pc_nxt_act = wb_pc_nxt_act;
   assign wb_bus.upd = wb_upd;

   bpu_gshare u_gshare
   (
      .clk           (clk),
      .arst_n        (arst_n),
      .re            (re),
      .insn_pc_1     (insn_pc_1),
      .insn_pc_2     (insn_pc_2),
      .pred_pc_nxt_1 (pred_pc_nxt_1),
      .pred_pc_nxt_2 (pred_pc_nxt_2),
      .pred_upd_1    (pred_upd_1),
      .pred_upd_2    (pred_upd_2),
      .wb_sink       (wb_bus)
   );

endmodule

// ==== sim/tb_bpu.sv ====
//----------------------------------------------------------
// BPU testbench
// Replays lookups and writebacks from the stimulus file,
// checks next-PC predictions and update words
//----------------------------------------------------------
`timescale 1ns/1ps

module tb_bpu
   import bpu_types_pkg::*;
();

   localparam string stim_path = "sim/bpu_stim.txt";

   logic     clk;
   logic     arst_n;
   logic     re;
   pc_t      insn_pc_1;
   pc_t      insn_pc_2;
   pc_t      pred_pc_nxt_1;
   pc_t      pred_pc_nxt_2;
   bpu_upd_t pred_upd_1;
   bpu_upd_t pred_upd_2;
   logic     wb;
   logic     wb_is_bcc;
   logic     wb_is_breg;
   logic     wb_taken;
   pc_t      wb_pc;
   pc_t      wb_pc_nxt_act;
   bpu_upd_t wb_upd;

   // Predictions of the latest lookup, held while re is low
   pc_t      exp_nxt_1;
   pc_t      exp_nxt_2;
   bpu_upd_t exp_upd_1;
   bpu_upd_t exp_upd_2;

   int cycles = 0;
   int limit = 0;

   bpu_top UUT
   (
      .clk           (clk),
      .arst_n        (arst_n),
      .re            (re),
      .insn_pc_1     (insn_pc_1),
      .insn_pc_2     (insn_pc_2),
      .pred_pc_nxt_1 (pred_pc_nxt_1),
      .pred_pc_nxt_2 (pred_pc_nxt_2),
      .pred_upd_1    (pred_upd_1),
      .pred_upd_2    (pred_upd_2),
      .wb            (wb),
      .wb_is_bcc     (wb_is_bcc),
      .wb_is_breg    (wb_is_breg),
      .wb_taken      (wb_taken),
      .wb_pc         (wb_pc),
      .wb_pc_nxt_act (wb_pc_nxt_act),
      .wb_upd        (wb_upd)
   );

   initial clk = 1'b0;
   always #10 clk = ~clk;

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("Test failed");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected)
         abort_run($sformatf("error: %s expected %h actual %h", name, expected, actual));
   endtask

   task automatic check_outputs(input int line_no);
      check_value($sformatf("line %0d pred_pc_nxt_1", line_no),
                  32'(exp_nxt_1), 32'(pred_pc_nxt_1));
      check_value($sformatf("line %0d pred_pc_nxt_2", line_no),
                  32'(exp_nxt_2), 32'(pred_pc_nxt_2));
      check_value($sformatf("line %0d pred_upd_1", line_no),
                  32'(exp_upd_1), 32'(pred_upd_1));
      check_value($sformatf("line %0d pred_upd_2", line_no),
                  32'(exp_upd_2), 32'(pred_upd_2));
   endtask

   // One cycle of latency, results checked right after the edge
   task automatic run_lookup(input int fd, input int line_no);
      int  code;
      pc_t pc_a;
      pc_t pc_b;
      code = $fscanf(fd, "%h %h %h %h %h %h", pc_a, pc_b,
                     exp_nxt_1, exp_nxt_2, exp_upd_1, exp_upd_2);
      if (code != 6)
         abort_run($sformatf("line %0d: a lookup needs six fields", line_no));
      re = 1'b1;
      insn_pc_1 = pc_a;
      insn_pc_2 = pc_b;
      @(posedge clk);
      #1;
      re = 1'b0;
      check_outputs(line_no);
   endtask

   task automatic run_writeback(input int fd, input int line_no);
      int code;
      code = $fscanf(fd, "%h %h %h %h %h %h", wb_is_bcc, wb_is_breg, wb_taken,
                     wb_pc, wb_pc_nxt_act, wb_upd);
      if (code != 6)
         abort_run($sformatf("line %0d: a writeback needs six fields", line_no));
      wb = 1'b1;
      @(posedge clk);
      #1;
      wb = 1'b0;
   endtask

   // New PCs with re low must not reach the outputs
   task automatic run_hold(input int fd, input int line_no);
      int  code;
      pc_t pc_a;
      pc_t pc_b;
      code = $fscanf(fd, "%h %h", pc_a, pc_b);
      if (code != 2)
         abort_run($sformatf("line %0d: a hold needs two fields", line_no));
      insn_pc_1 = pc_a;
      insn_pc_2 = pc_b;
      @(posedge clk);
      #1;
      check_outputs(line_no);
   endtask

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (limit > 0 && cycles >= limit)
         abort_run($sformatf("timeout: run did not finish within %0d cycles", limit));
   end

   initial
   begin
      int               fd;
      int               code;
      int               n_lines;
      int               line_no;
      int               n_cmds;
      logic [7:0]       op;
      logic [8*200-1:0] line_buf;

      arst_n = 1'b0;
      re = 1'b0;
      insn_pc_1 = '0;
      insn_pc_2 = '0;
      wb = 1'b0;
      wb_is_bcc = 1'b0;
      wb_is_breg = 1'b0;
      wb_taken = 1'b0;
      wb_pc = '0;
      wb_pc_nxt_act = '0;
      wb_upd = '0;
      exp_nxt_1 = '0;
      exp_nxt_2 = '0;
      exp_upd_1 = '0;
      exp_upd_2 = '0;

      // Size the timeout from the file length
      fd = $fopen(stim_path, "r");
      if (fd == 0)
         abort_run("the stimulus file could not be opened");
      n_lines = 0;
      while ($fgets(line_buf, fd) != 0)
         n_lines++;
      $fclose(fd);
      limit = n_lines * 4 + 20;

      repeat (3) @(posedge clk);
      #1;
      arst_n = 1'b1;

      fd = $fopen(stim_path, "r");
      line_no = 0;
      n_cmds = 0;
      code = $fscanf(fd, "%s", op);
      while (code == 1)
      begin
         line_no++;
         case (op)
            "#": code = $fgets(line_buf, fd);
            "L": run_lookup(fd, line_no);
            "W": run_writeback(fd, line_no);
            "H": run_hold(fd, line_no);
            default: abort_run($sformatf("line %0d: unknown command", line_no));
         endcase
         if (op != "#")
            n_cmds++;
         code = $fscanf(fd, "%s", op);
      end
      $fclose(fd);

      repeat (2) @(posedge clk);
      if (n_cmds > 0)
      begin
         $display("Test passed");
         $finish;
      end
      else
      begin
         abort_run("the stimulus file holds no commands");
      end
   end

endmodule

// ==== sim/bpu_stim.txt ====
# L pc_1 pc_2 exp_pc_nxt_1 exp_pc_nxt_2 exp_upd_1 exp_upd_2 (lookup, all hex)
# W is_bcc is_breg taken pc pc_nxt_act upd (writeback)   H pc_1 pc_2 (re low)
# cold lookups with zero history and counters at 01
L 00000100 00000245 00000101 00000246 20000 21145
# register branch installs a target and keeps the history
W 0 1 1 00000245 00003000 21145
L 00000245 00000285 00003000 00000286 21145 22145
H 00000310 00000777
# conditional branch, taken outcomes fill the history with ones
L 00000310 00000245 00000311 00003000 20410 21145
W 1 0 1 00000310 00000500 20410
L 00000310 00000245 00000311 00003000 20450 21105
W 1 0 1 00000310 00000500 20450
L 00000310 00000245 00000311 00003000 204D0 21185
W 1 0 1 00000310 00000500 204D0
L 00000310 00000245 00000311 00003000 205D0 21085
W 1 0 1 00000310 00000500 205D0
L 00000310 00000245 00000311 00003000 207D0 21285
W 1 0 1 00000310 00000500 207D0
L 00000310 00000245 00000311 00003000 203D0 21685
W 1 0 1 00000310 00000500 203D0
L 00000310 00000245 00000311 00003000 20BD0 21E85
W 1 0 1 00000310 00000500 20BD0
L 00000310 00000245 00000311 00003000 21BD0 20E85
W 1 0 1 00000310 00000500 21BD0
# history saturated, the same counter now trains up
L 00000310 00000245 00000311 00003000 23BD0 22E85
W 1 0 1 00000310 00000500 23BD0
L 00000310 00000245 00000500 00003000 37BD0 22E85
W 1 0 1 00000310 00000500 37BD0
L 00000310 00000245 00000500 00003000 3BBD0 22E85
H 00000245 00000100
# not-taken outcome shifts a zero into the history
W 1 0 0 00000310 00000311 3BBD0
L 00000310 00000245 00000311 00003000 23B90 22EC5
H 00000000 00000000
# channels swapped, tag miss on one side
L 00000285 00000310 00000286 00000311 21EC5 23B90

// ==== tb.f ====
hw/bpu_cfg_pkg.sv
hw/bpu_types_pkg.sv
hw/bpu_wb_if.sv
hw/mpram_1w2r.sv
hw/bpu_btb.sv
hw/bpu_pht.sv
hw/bpu_gshare.sv
hw/bpu_top.sv
sim/tb_bpu.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the BPU testbench with Verilator.
# The result is taken from the simulation log.

cd "$(dirname "$0")" || exit 1

obj_dir=obj_dir
log_file=sim.log

verilator --binary --timing --top-module tb_bpu -Mdir "$obj_dir" -f tb.f
if [ $? -ne 0 ]; then
   echo "verilator compile step returned an error"
   exit 1
fi

"./$obj_dir/Vtb_bpu" > "$log_file" 2>&1
run_status=$?
cat "$log_file"

if grep -q "Test failed" "$log_file"; then
   echo "simulation reported a failure"
   exit 1
fi

if [ $run_status -ne 0 ]; then
   echo "simulator exited with status $run_status"
   exit 1
fi

echo "simulation finished without failures"
exit 0
